// File: mb_settings.svh
/* memory bridge constants: register offsets, word widths, burst size,
   buffer page geometry and reset values */
`ifndef MB_SETTINGS_SVH
`define MB_SETTINGS_SVH

`define MB_ADDR64_W    29     // word address and length width
`define MB_DATA_W      64
`define MB_BURST_LEN   16     // beats per full burst
`define MB_PAGE_WORDS  128
`define MB_PAGES       4
`define MB_WIDTH_W     14     // frame width field

// wishbone word offsets
`define MB_REG_CTRL    3'd0
`define MB_REG_LO_ADDR 3'd1
`define MB_REG_SIZE    3'd2
`define MB_REG_START   3'd3
`define MB_REG_LEN     3'd4
`define MB_REG_WIDTH   3'd5
`define MB_REG_MODE    3'd6
`define MB_REG_STATUS  3'd7

`define MB_MODE_RESET  4'd3   // default cache attribute

`endif

// File: mb_pkg.sv
/* memory bridge types: bus groups, configuration set and enums */
`default_nettype none
`include "mb_settings.svh"

package mb_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;  // word offset
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;  // valid with ack
    } wb_rsp_t;

    typedef struct packed {
        logic [31:0] addr; // byte address
        logic [3:0]  len;  // beats minus 1
        logic [3:0]  cache;
    } axi_aw_t;

    typedef struct packed {
        logic [`MB_DATA_W-1:0] data;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic                  we;
        logic                  next_page;
        logic [`MB_DATA_W-1:0] data;
    } buf_wr_t;

    typedef struct packed {
        logic [`MB_ADDR64_W-1:0] lo_addr64;  // window base, 16-word aligned
        logic [`MB_ADDR64_W-1:0] size64;     // window size
        logic [`MB_ADDR64_W-1:0] start64;    // start relative to lo_addr64
        logic [`MB_ADDR64_W-1:0] len64;      // words per transfer
        logic [`MB_WIDTH_W-1:0]  width64;    // words per frame line
        logic                    reset_addr; // reload start64 on start
        logic [3:0]              cache;
    } mb_cfg_t;

    // ctrl bits 2:1
    typedef enum logic [1:0] {
        cmd_none        = 2'b00,
        cmd_start_reset = 2'b01,
        cmd_continue    = 2'b11
    } ctrl_cmd_e;

    typedef enum logic [1:0] {
        xs_idle,
        xs_run,
        xs_drain
    } xfer_state_e;

endpackage

`default_nettype wire

// File: mb_regs.sv
/* memory bridge register file: wishbone classic slave with configuration,
   start pulse generation and readable status */
`timescale 1ns/1ps
`default_nettype none
`include "mb_settings.svh"

module mb_regs (
    input  wire                  hclk,
    input  wire                  hrst,
    input  wire mb_pkg::wb_req_t wb_i,
    output mb_pkg::wb_rsp_t      wb_o,
    input  wire                  busy_i,
    input  wire                  done_i,
    input  wire [7:0]            bursts_i,
    output mb_pkg::mb_cfg_t      cfg_o,
    output logic                 start_o,
    output logic                 en_o
);
    mb_pkg::ctrl_cmd_e cmd;
    logic              req;
    logic              wr;
    logic [31:0]       rdat;
    logic              cmd_start;

    assign req       = wb_i.cyc && wb_i.stb && !wb_o.ack; // not during our own ack
    assign wr        = req && wb_i.we;
    assign cmd       = mb_pkg::ctrl_cmd_e'(wb_i.dat[2:1]);
    assign cmd_start = (cmd == mb_pkg::cmd_start_reset) || (cmd == mb_pkg::cmd_continue);

    always_comb begin
        rdat = '0;
        case (wb_i.adr)
            `MB_REG_CTRL:    rdat[0] = en_o;
            `MB_REG_LO_ADDR: rdat[`MB_ADDR64_W-1:0] = cfg_o.lo_addr64;
            `MB_REG_SIZE:    rdat[`MB_ADDR64_W-1:0] = cfg_o.size64;
            `MB_REG_START:   rdat[`MB_ADDR64_W-1:0] = cfg_o.start64;
            `MB_REG_LEN:     rdat[`MB_ADDR64_W-1:0] = cfg_o.len64;
            `MB_REG_WIDTH:   rdat[`MB_WIDTH_W-1:0] = cfg_o.width64;
            `MB_REG_MODE:    rdat[3:0] = cfg_o.cache;
            `MB_REG_STATUS:  rdat[9:0] = {bursts_i, done_i, busy_i};
            default:         rdat = '0;
        endcase
    end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            wb_o        <= '0;
            cfg_o       <= '0;
            cfg_o.cache <= `MB_MODE_RESET;
            start_o     <= 1'b0;
            en_o        <= 1'b0;
        end else begin
            wb_o.ack <= req;   // single-cycle ack
            start_o  <= 1'b0;
            if (req) begin
                wb_o.dat <= rdat;
            end
            if (wr) begin
                case (wb_i.adr)
                    `MB_REG_CTRL: begin
                        en_o             <= wb_i.dat[0];
                        start_o          <= wb_i.dat[0] && cmd_start; // lands in ack cycle
                        cfg_o.reset_addr <= (cmd == mb_pkg::cmd_start_reset);
                    end
                    `MB_REG_LO_ADDR: begin
                        cfg_o.lo_addr64 <= {wb_i.dat[`MB_ADDR64_W-1:4], 4'd0};
                        cfg_o.start64   <= '0;  // new window restarts at its base
                    end
                    `MB_REG_SIZE:  cfg_o.size64  <= {wb_i.dat[`MB_ADDR64_W-1:4], 4'd0};
                    `MB_REG_START: cfg_o.start64 <= {wb_i.dat[`MB_ADDR64_W-1:4], 4'd0};
                    `MB_REG_LEN:   cfg_o.len64   <= wb_i.dat[`MB_ADDR64_W-1:0]; // any length
                    `MB_REG_WIDTH: cfg_o.width64 <= wb_i.dat[`MB_WIDTH_W-1:0];
                    `MB_REG_MODE:  cfg_o.cache   <= wb_i.dat[3:0];
                    default: ;     // status is read only
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: mb_page_buf.sv
/* four-page line buffer: sequential fill port, one-cycle read port */
`timescale 1ns/1ps
`default_nettype none
`include "mb_settings.svh"

module mb_page_buf (
    input  wire                   hclk,
    input  wire                   hrst,
    input  wire mb_pkg::buf_wr_t  fill_i,
    input  wire                   rd_i,
    input  wire [8:0]             raddr_i,
    output logic [`MB_DATA_W-1:0] rdata_o
);
    logic [`MB_DATA_W-1:0] mem [`MB_PAGES*`MB_PAGE_WORDS];
    logic [1:0]            wpage;   // page being filled
    logic [6:0]            wword;   // next word in that page

    always_ff @(posedge hclk) begin
        if (hrst) begin
            wpage <= '0;
            wword <= '0;
        end else if (fill_i.next_page) begin
            wpage <= wpage + 2'd1;  // modulo 4
            wword <= '0;
        end else if (fill_i.we) begin
            wword <= wword + 7'd1;
        end
    end

    always_ff @(posedge hclk) begin
        if (fill_i.we) begin
            mem[{wpage, wword}] <= fill_i.data;
        end
        if (rd_i) begin
            rdata_o <= mem[raddr_i];  // valid next cycle
        end
    end

endmodule

`default_nettype wire

// File: mb_addr_gen.sv
/* burst address generator: steps through the system memory window
   in 16-word bursts with rollover, drives the write address channel */
`timescale 1ns/1ps
`default_nettype none
`include "mb_settings.svh"

module mb_addr_gen (
    input  wire                  hclk,
    input  wire                  hrst,
    input  wire mb_pkg::mb_cfg_t cfg_i,
    input  wire                  start_i,
    input  wire                  run_i,
    output mb_pkg::axi_aw_t      aw_o,
    output logic                 aw_valid_o,
    input  wire                  aw_ready_i,
    output logic                 aw_fire_o
);
    localparam int aw_w = `MB_ADDR64_W;

    logic [aw_w-1:0] rel_addr;   // relative to lo_addr64
    logic [aw_w-1:0] left;       // words not yet addressed
    logic [aw_w-1:0] addr64;
    logic            last_burst; // look-ahead, one cycle behind left
    logic            rollover;   // current burst is the last in window
    logic [3:0]      len_nxt;
    logic            prime;      // lets look-ahead settle after start
    logic            issue;

    assign aw_fire_o = aw_valid_o && aw_ready_i;
    assign addr64    = cfg_i.lo_addr64 + rel_addr;
    assign issue     = run_i && !start_i && !prime && !aw_valid_o && (left != '0);

    always_ff @(posedge hclk) begin
        last_burst <= !(|left[aw_w-1:4]);
        rollover   <= rel_addr[aw_w-1:4] == (cfg_i.size64[aw_w-1:4] - 1'b1);
        len_nxt    <= (|left[aw_w-1:4]) ? 4'hf : (left[3:0] - 4'd1); // partial tail
    end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            aw_valid_o <= 1'b0;
            prime      <= 1'b0;
            rel_addr   <= '0;
            left       <= '0;
        end else begin
            prime <= start_i;
            if (start_i) begin
                left <= cfg_i.len64;
                if (cfg_i.reset_addr) begin
                    rel_addr <= cfg_i.start64;  // else continue from last stop
                end
            end else if (issue) begin
                left <= last_burst ? '0 : (left - aw_w'(`MB_BURST_LEN));
                if (last_burst) begin
                    rel_addr <= rel_addr + left[3:0];
                end else if (rollover) begin
                    rel_addr <= '0;             // wrap to window base
                end else begin
                    rel_addr <= rel_addr + aw_w'(`MB_BURST_LEN);
                end
            end
            if (issue) begin
                aw_valid_o <= 1'b1;
            end else if (aw_ready_i) begin
                aw_valid_o <= 1'b0;             // held until accepted
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (issue) begin
            aw_o.addr  <= {addr64, 3'b000};     // words to bytes
            aw_o.len   <= len_nxt;
            aw_o.cache <= cfg_i.cache;
        end
    end

endmodule

`default_nettype wire

// File: mb_data_seq.sv
/* buffer data sequencer: walks frame lines through the page buffer and
   streams the words as write data beats with wlast */
`timescale 1ns/1ps
`default_nettype none
`include "mb_settings.svh"

module mb_data_seq (
    input  wire                   hclk,
    input  wire                   hrst,
    input  wire mb_pkg::mb_cfg_t  cfg_i,
    input  wire                   start_i,
    input  wire                   run_i,
    input  wire                   page_ready_i,
    output logic                  next_page_o,
    output logic                  rd_o,
    output logic [8:0]            raddr_o,
    input  wire [`MB_DATA_W-1:0]  rdata_i,
    output mb_pkg::axi_w_t        w_o,
    output logic                  w_valid_o,
    input  wire                   w_ready_i,
    output logic                  left_zero_o
);
    localparam int aw_w = `MB_ADDR64_W;
    localparam int ww_w = `MB_WIDTH_W;

    logic [aw_w-1:0] left;         // words not yet read
    logic [ww_w-1:0] col;          // column in current line
    logic [1:0]      rpage;        // buffer page being read
    logic [2:0]      pages_ready;
    logic [3:0]      beat;         // beat in burst
    logic            last_word;
    logic            last_in_line;
    logic            last_in_page;
    logic            rd_d;         // read in flight
    logic            last_d;       // wlast for the word in flight
    logic [1:0]      occ;          // output stage entries
    logic            pop;
    mb_pkg::axi_w_t  q0;
    mb_pkg::axi_w_t  q1;
    mb_pkg::axi_w_t  q_new;

    assign last_word    = left == aw_w'(1);
    assign last_in_line = col == (cfg_i.width64 - 1'b1);
    assign last_in_page = last_in_line || (&col[6:0]) || last_word; // tail frees page too
    assign pop          = w_valid_o && w_ready_i;
    assign rd_o         = run_i && (left != '0) && (pages_ready != 3'd0)
                          && ((3'(occ) + 3'(rd_d) - 3'(pop)) < 3'd2); // room incl. in flight
    assign raddr_o      = {rpage, col[6:0]};
    assign q_new        = '{data: rdata_i, last: last_d};
    assign w_o          = q0;
    assign w_valid_o    = occ != 2'd0;
    assign left_zero_o  = (left == '0) && !rd_d && (occ == 2'd0); // all beats gone

    always_ff @(posedge hclk) begin
        if (hrst) begin
            left        <= '0;
            col         <= '0;
            beat        <= '0;
            rpage       <= '0;
            pages_ready <= '0;
            next_page_o <= 1'b0;
            rd_d        <= 1'b0;
            occ         <= '0;
        end else begin
            next_page_o <= rd_o && last_in_page;
            pages_ready <= pages_ready + 3'(page_ready_i) - 3'(rd_o && last_in_page);
            rd_d        <= rd_o;
            occ         <= occ + 2'(rd_d) - 2'(pop);
            if (start_i) begin
                left <= cfg_i.len64;
                col  <= '0;
                beat <= '0;
            end else if (rd_o) begin
                left <= left - 1'b1;
                col  <= last_in_line ? '0 : (col + 1'b1);
                beat <= beat + 4'd1;
            end
            if (rd_o && last_in_page) begin
                rpage <= rpage + 2'd1;
            end
        end
    end

    // two-entry output stage, q0 is the head
    always_ff @(posedge hclk) begin
        if (rd_o) begin
            last_d <= (&beat) || last_word;     // every 16th and the final beat
        end
        case ({rd_d, pop})
            2'b10: begin
                if (occ == 2'd0) begin
                    q0 <= q_new;
                end else begin
                    q1 <= q_new;
                end
            end
            2'b01: q0 <= q1;
            2'b11: begin
                if (occ == 2'd1) begin
                    q0 <= q_new;
                end else begin
                    q0 <= q1;
                    q1 <= q_new;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: mb_xfer_ctrl.sv
/* transfer controller: tracks issued bursts and write responses,
   runs the engines and forms busy and done */
`timescale 1ns/1ps
`default_nettype none
`include "mb_settings.svh"

module mb_xfer_ctrl (
    input  wire                  hclk,
    input  wire                  hrst,
    input  wire mb_pkg::mb_cfg_t cfg_i,
    input  wire                  start_i,
    input  wire                  en_i,
    input  wire                  aw_fire_i,
    input  wire                  left_zero_i,
    input  wire                  b_valid_i,
    output logic                 run_o,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [7:0]           bursts_o
);
    localparam int aw_w = `MB_ADDR64_W;

    mb_pkg::xfer_state_e state;
    logic [aw_w-5:0]     aw_left;  // bursts still to be addressed
    logic [7:0]          resps;
    logic                all_sent;
    logic                all_acked;

    assign all_sent  = left_zero_i && (aw_left == '0);
    assign all_acked = resps == bursts_o;
    assign run_o     = state == mb_pkg::xs_run;
    assign busy_o    = state != mb_pkg::xs_idle;

    always_ff @(posedge hclk) begin
        if (hrst) begin
            state    <= mb_pkg::xs_idle;
            aw_left  <= '0;
            bursts_o <= '0;
            resps    <= '0;
            done_o   <= 1'b0;
        end else begin
            if (aw_fire_i) begin
                bursts_o <= bursts_o + 8'd1;
                aw_left  <= aw_left - 1'b1;
            end
            if (b_valid_i) begin
                resps <= resps + 8'd1;  // b_ready is always high
            end
            case (state)
                mb_pkg::xs_idle: begin
                    if (start_i && en_i) begin
                        state    <= mb_pkg::xs_run;
                        aw_left  <= cfg_i.len64[aw_w-1:4] + (|cfg_i.len64[3:0]); // ceil /16
                        bursts_o <= '0;
                        resps    <= '0;
                    end
                end
                mb_pkg::xs_run: begin
                    if (all_sent) begin
                        state <= mb_pkg::xs_drain;
                    end
                end
                mb_pkg::xs_drain: begin
                    if (all_acked) begin
                        state <= mb_pkg::xs_idle; // busy falls with done rising
                    end
                end
                default: state <= mb_pkg::xs_idle;
            endcase
            if (start_i || !en_i) begin
                done_o <= 1'b0;
            end else if ((state == mb_pkg::xs_drain) && all_acked) begin
                done_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: membridge_top.sv
/* memory bridge top: moves frame data from the page buffer to system
   memory as 16-beat write bursts, programmed over wishbone */
`timescale 1ns/1ps
`default_nettype none

module membridge_top (
    input  wire                  hclk,
    input  wire                  hrst,
    input  wire mb_pkg::wb_req_t wb_i,
    output wire mb_pkg::wb_rsp_t wb_o,
    input  wire mb_pkg::buf_wr_t fill_i,
    input  wire                  page_ready_i,
    output wire                  next_page_o,
    output wire mb_pkg::axi_aw_t aw_o,
    output wire                  aw_valid_o,
    input  wire                  aw_ready_i,
    output wire mb_pkg::axi_w_t  w_o,
    output wire                  w_valid_o,
    input  wire                  w_ready_i,
    input  wire                  b_valid_i,
    output wire                  b_ready_o,
    output wire                  busy_o,
    output wire                  done_o
);
    mb_pkg::mb_cfg_t cfg;
    wire             start;
    wire             en;
    wire             run;
    wire             aw_fire;
    wire             left_zero;
    wire [7:0]       bursts;
    wire             buf_rd;
    wire [8:0]       buf_raddr;
    wire [63:0]      buf_rdata;

    assign b_ready_o = 1'b1;  // responses only counted

    mb_regs u_regs (
        .hclk     (hclk),
        .hrst     (hrst),
        .wb_i     (wb_i),
        .wb_o     (wb_o),
        .busy_i   (busy_o),
        .done_i   (done_o),
        .bursts_i (bursts),
        .cfg_o    (cfg),
        .start_o  (start),
        .en_o     (en)
    );

    mb_page_buf u_buf (
        .hclk    (hclk),
        .hrst    (hrst),
        .fill_i  (fill_i),
        .rd_i    (buf_rd),
        .raddr_i (buf_raddr),
        .rdata_o (buf_rdata)
    );

    mb_addr_gen u_addr (
        .hclk       (hclk),
        .hrst       (hrst),
        .cfg_i      (cfg),
        .start_i    (start),
        .run_i      (run),
        .aw_o       (aw_o),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready_i),
        .aw_fire_o  (aw_fire)
    );

    mb_data_seq u_data (
        .hclk         (hclk),
        .hrst         (hrst),
        .cfg_i        (cfg),
        .start_i      (start),
        .run_i        (run),
        .page_ready_i (page_ready_i),
        .next_page_o  (next_page_o),
        .rd_o         (buf_rd),
        .raddr_o      (buf_raddr),
        .rdata_i      (buf_rdata),
        .w_o          (w_o),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .left_zero_o  (left_zero)
    );

    mb_xfer_ctrl u_ctrl (
        .hclk        (hclk),
        .hrst        (hrst),
        .cfg_i       (cfg),
        .start_i     (start),
        .en_i        (en),
        .aw_fire_i   (aw_fire),
        .left_zero_i (left_zero),
        .b_valid_i   (b_valid_i),
        .run_o       (run),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .bursts_o    (bursts)
    );

endmodule

`default_nettype wire

// File: tb_membridge_sva.sv
/* memory bridge port checker: channel hold rules, page accounting
   and busy/done exclusion, bound into the bridge top */
`timescale 1ns/1ps
`default_nettype none

module tb_membridge_sva (
    input wire                  hclk,
    input wire                  hrst,
    input wire mb_pkg::axi_aw_t aw_i,
    input wire                  aw_valid_i,
    input wire                  aw_ready_i,
    input wire mb_pkg::axi_w_t  w_i,
    input wire                  w_valid_i,
    input wire                  w_ready_i,
    input wire                  page_ready_i,
    input wire                  next_page_i,
    input wire                  busy_i,
    input wire                  done_i
);
    int granted;       // pages offered minus pages freed
    int fail_cnt = 0;  // read by the testbench at the end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            granted <= 0;
        end else begin
            granted <= granted + int'(page_ready_i) - int'(next_page_i);
        end
    end

    aw_hold: assert property (@(posedge hclk) disable iff (hrst)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
        else begin
            fail_cnt++;
            $error("write address changed or dropped while held");
        end

    w_hold: assert property (@(posedge hclk) disable iff (hrst)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
        else begin
            fail_cnt++;
            $error("write data changed or dropped while held");
        end

    page_free: assert property (@(posedge hclk) disable iff (hrst)
        next_page_i |-> granted > 0)
        else begin
            fail_cnt++;
            $error("page freed that was never marked ready");
        end

    busy_done: assert property (@(posedge hclk) disable iff (hrst)
        !(busy_i && done_i))
        else begin
            fail_cnt++;
            $error("busy and done high together");
        end

endmodule

bind membridge_top tb_membridge_sva u_sva (
    .hclk         (hclk),
    .hrst         (hrst),
    .aw_i         (aw_o),
    .aw_valid_i   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .w_i          (w_o),
    .w_valid_i    (w_valid_o),
    .w_ready_i    (w_ready_i),
    .page_ready_i (page_ready_i),
    .next_page_i  (next_page_o),
    .busy_i       (busy_o),
    .done_i       (done_o)
);

`default_nettype wire

// File: tb_membridge.sv
/* memory bridge testbench with wishbone setup, a page filler, a write slave
   with back-pressure and address and data stream checks */
`timescale 1ns/1ps
`default_nettype none
`include "mb_settings.svh"

module tb_membridge;
    localparam int total_words = 64 + 300 + 96 + 256 + 48;
    localparam int cycle_limit = 8 * total_words + 2000;

    logic            hclk;
    logic            hrst;
    mb_pkg::wb_req_t wb_req;
    mb_pkg::wb_rsp_t wb_rsp;
    mb_pkg::buf_wr_t fill;
    logic            page_ready;
    logic            next_page;
    mb_pkg::axi_aw_t aw;
    logic            aw_valid;
    logic            aw_ready;
    mb_pkg::axi_w_t  w;
    logic            w_valid;
    logic            w_ready;
    logic            b_valid;
    logic            b_ready;
    logic            busy;
    logic            done;

    int cycles;
    int errors;
    int checks;
    int tests;
    int test_err;      // error count when the test began
    int pages_filled;
    int pages_freed;
    int n_aw;
    int n_beat;
    int n_b;
    int b_due[$];      // cycle at which each response goes out
    bit bp_on;         // random ready back-pressure
    int m_lo;          // programmed window model in words
    int m_size;
    int m_start;
    int m_rel;
    int m_len;
    int m_width;
    int m_cache;

    membridge_top u_dut (
        .hclk         (hclk),
        .hrst         (hrst),
        .wb_i         (wb_req),
        .wb_o         (wb_rsp),
        .fill_i       (fill),
        .page_ready_i (page_ready),
        .next_page_o  (next_page),
        .aw_o         (aw),
        .aw_valid_o   (aw_valid),
        .aw_ready_i   (aw_ready),
        .w_o          (w),
        .w_valid_o    (w_valid),
        .w_ready_i    (w_ready),
        .b_valid_i    (b_valid),
        .b_ready_o    (b_ready),
        .busy_o       (busy),
        .done_o       (done)
    );

    always #50 hclk = ~hclk;

    // buffer word tag from stream page count and offset
    function automatic logic [63:0] page_word(input int pc, input int off);
        return {8'hd5, 24'(pc), 32'(off)};
    endfunction

    function automatic int page_of(input int n);
        int line;
        int col;
        line = n / m_width;
        col  = n % m_width;
        return line * ((m_width + 127) / 128) + col / 128;
    endfunction

    function automatic logic [63:0] stream_word(input int n);
        return page_word(page_of(n), (n % m_width) % 128);
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_aw();
        int words;
        words = m_len - 16 * n_aw;
        check_val("aw_o.addr", aw.addr, 32'((m_lo + m_rel) * 8));
        check_val("aw_o.len", aw.len, (words >= 16) ? 15 : words - 1);
        check_val("aw_o.cache", aw.cache, m_cache);
        if (words < 16) begin
            m_rel = m_rel + words;                   // partial tail
        end else if (m_rel / 16 == m_size / 16 - 1) begin
            m_rel = 0;                               // window rollover
        end else begin
            m_rel = m_rel + 16;
        end
        n_aw++;
    endtask

    task automatic check_w();
        logic exp_last;
        exp_last = (n_beat % 16 == 15) || (n_beat == m_len - 1);
        check_val("w_o.data", w.data, stream_word(n_beat));
        check_val("w_o.last", w.last, exp_last);
        if (w.last) begin
            b_due.push_back(cycles + 1 + $urandom % 6); // answer after a delay
        end
        n_beat++;
    endtask

    // cycle count and output monitor on pre-edge values
    always @(posedge hclk) begin
        cycles++;
        if (!hrst) begin
            if (aw_valid && aw_ready) check_aw();
            if (w_valid && w_ready) check_w();
            if (next_page) pages_freed++;
        end
    end

    // run limit
    initial begin
        wait (cycles > cycle_limit);
        $display("timeout: run passed %0d cycles without finishing", cycle_limit);
        $display("Something failed");
        $finish;
    end

    // slave handshake inputs driven just after the edge
    always @(posedge hclk) begin
        #1;
        aw_ready = bp_on ? ($urandom % 3 != 0) : 1'b1;
        w_ready  = bp_on ? ($urandom % 4 != 0) : 1'b1;
        b_valid  = 1'b0;
        if (b_due.size() != 0 && b_due[0] <= cycles) begin
            b_valid = 1'b1;
            void'(b_due.pop_front());
            n_b++;
        end
    end

    task automatic wb_access(input logic we, input logic [2:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        n = 0;
        do begin
            @(posedge hclk);
            #1;
            n++;
        end while (!wb_rsp.ack && n < 8);
        if (!wb_rsp.ack) begin
            errors++;
            $display("wishbone access to offset %0d was never acknowledged", adr);
        end
        check_val("wb ack latency", n, 1);
        rdat   = wb_rsp.dat;
        wb_req = '0;
        @(posedge hclk);  // idle cycle between accesses
        #1;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, input logic [31:0] exp,
                           input string name);
        logic [31:0] rdat;
        wb_access(1'b0, adr, 32'd0, rdat);
        check_val(name, rdat, exp);
    endtask

    // fills whole tagged pages with at most four outstanding
    task automatic fill_pages(input int npages);
        int p;
        int k;
        for (p = 0; p < npages; p++) begin
            while (pages_filled - pages_freed >= 4) begin
                @(posedge hclk);
                #1;
            end
            for (k = 0; k < 128; k++) begin
                fill.we   = 1'b1;
                fill.data = page_word(p, k);
                @(posedge hclk);
                #1;
            end
            fill.we        = 1'b0;
            fill.next_page = 1'b1;
            page_ready     = 1'b1;
            @(posedge hclk);
            #1;
            fill.next_page = 1'b0;
            page_ready     = 1'b0;
            pages_filled++;
        end
    endtask

    task automatic setup(input int lo, input int size, input int start,
                         input int len, input int width);
        wb_write(`MB_REG_LO_ADDR, lo);
        wb_write(`MB_REG_SIZE, size);
        wb_write(`MB_REG_START, start);
        wb_write(`MB_REG_LEN, len);
        wb_write(`MB_REG_WIDTH, width);
        m_lo    = lo & ~15;
        m_size  = size & ~15;
        m_start = start & ~15;
        m_len   = len;
        m_width = width;
    endtask

    task automatic run_xfer(input mb_pkg::ctrl_cmd_e cmd);
        int nb;
        nb     = (m_len + 15) / 16;
        n_aw   = 0;
        n_beat = 0;
        n_b    = 0;
        if (cmd == mb_pkg::cmd_start_reset) m_rel = m_start;
        wb_write(`MB_REG_CTRL, {29'd0, cmd, 1'b1});
        check_val("busy_o", busy, 1);
        fork
            fill_pages(page_of(m_len - 1) + 1);
            while (!done) begin
                @(posedge hclk);
                #1;
            end
        join
        check_val("beats", n_beat, m_len);
        check_val("bursts", n_aw, nb);
        check_val("responses", n_b, nb);
        check_val("busy_o", busy, 0);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == test_err) ? "ok" : "failed", errors - test_err);
        test_err = errors;
    endtask

    initial begin
        void'($urandom(32'h0f06d54a));
        hclk         = 1'b0;
        hrst         = 1'b1;
        wb_req       = '0;
        fill         = '0;
        page_ready   = 1'b0;
        aw_ready     = 1'b0;
        w_ready      = 1'b0;
        b_valid      = 1'b0;
        bp_on        = 1'b0;
        cycles       = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        test_err     = 0;
        pages_filled = 0;
        pages_freed  = 0;
        m_cache      = `MB_MODE_RESET;
        repeat (4) @(posedge hclk);
        #1;
        hrst = 1'b0;

        // outputs low out of reset
        check_val("aw_valid_o", aw_valid, 0);
        check_val("w_valid_o", w_valid, 0);
        check_val("next_page_o", next_page, 0);
        check_val("busy_o", busy, 0);
        check_val("done_o", done, 0);

        // register file reset values then aligned write and read back
        wb_read(`MB_REG_MODE, `MB_MODE_RESET, "MODE reset");
        wb_read(`MB_REG_CTRL, 0, "CTRL reset");
        wb_read(`MB_REG_STATUS, 0, "STATUS reset");
        wb_read(`MB_REG_LEN, 0, "LEN reset");
        wb_read(`MB_REG_LO_ADDR, 0, "LO_ADDR reset");
        wb_read(`MB_REG_SIZE, 0, "SIZE reset");
        wb_read(`MB_REG_START, 0, "START reset");
        wb_read(`MB_REG_WIDTH, 0, "WIDTH reset");
        wb_write(`MB_REG_START, 32'h0000_0abc);
        wb_read(`MB_REG_START, 32'h0000_0ab0, "START");
        wb_write(`MB_REG_LO_ADDR, 32'hf234_5678);
        wb_read(`MB_REG_LO_ADDR, 32'hf234_5678 & 32'h1fff_fff0, "LO_ADDR");
        wb_read(`MB_REG_START, 0, "START after LO_ADDR");
        wb_write(`MB_REG_SIZE, 32'h0001_23ff);
        wb_read(`MB_REG_SIZE, 32'h0001_23f0, "SIZE");
        wb_write(`MB_REG_LEN, 32'hffff_ffff);
        wb_read(`MB_REG_LEN, 32'h1fff_ffff, "LEN");
        wb_write(`MB_REG_WIDTH, 32'h0001_7fff);
        wb_read(`MB_REG_WIDTH, 32'h0000_3fff, "WIDTH");
        wb_write(`MB_REG_MODE, 32'h0000_005a);
        wb_read(`MB_REG_MODE, 32'h0000_000a, "MODE");
        m_cache = 32'h0000_000a;
        wb_write(`MB_REG_STATUS, 32'hffff_ffff);
        wb_read(`MB_REG_STATUS, 0, "STATUS read only");
        wb_write(`MB_REG_CTRL, 32'h1);     // enable without a command
        wb_read(`MB_REG_CTRL, 1, "CTRL");
        check_val("b_ready_o", b_ready, 1);
        end_test("register access");

        setup(32'h1000, 32'h400, 32'h20, 64, 128);
        run_xfer(mb_pkg::cmd_start_reset);
        end_test("full bursts");

        setup(32'h8000, 32'h1000, 0, 300, 200);
        run_xfer(mb_pkg::cmd_start_reset);
        end_test("partial burst and page");

        setup(32'h100, 64, 32, 96, 96);    // six bursts in a four-burst window
        run_xfer(mb_pkg::cmd_start_reset);
        end_test("window rollover");

        setup(32'h2000, 32'h1000, 32'h40, 256, 160);
        bp_on = 1'b1;
        run_xfer(mb_pkg::cmd_start_reset);
        bp_on = 1'b0;
        end_test("back-pressure");

        wb_write(`MB_REG_LEN, 48);
        wb_write(`MB_REG_WIDTH, 48);
        m_len   = 48;
        m_width = 48;
        run_xfer(mb_pkg::cmd_continue);    // resumes at 0x140 into the window
        wb_read(`MB_REG_STATUS, (3 << 2) | 2, "STATUS after continue");
        end_test("continue");

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, u_dut.u_sva.fail_cnt);
        if (errors == 0 && u_dut.u_sva.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
mb_pkg.sv
mb_regs.sv
mb_page_buf.sv
mb_addr_gen.sv
mb_data_seq.sv
mb_xfer_ctrl.sv
membridge_top.sv
tb_membridge_sva.sv
tb_membridge.sv
